/* Bender.yml */
package:
  name: m_cu

sources:
  - files:
      - design/mcu_pkg.sv
      - design/emul_lookup.sv
      - design/mcu_cfg_regs.sv
      - design/store_ctrl.sv
      - design/load_ctrl.sv
      - design/m_cu_top.sv
  - target: test
    files:
      - bench/m_cu_tb.sv

/* bench/m_cu_tb.sv */
/*
  Requests run one at a time so store and load never overlap.
  Buffers and the AXI side are simple behavioral responders.
*/
`timescale 1ns/1ps
`default_nettype none

module m_cu_tb;

  import mcu_pkg::*;

  localparam int  CLK_PERIOD     = 100;
  localparam int  NUM_REQ        = 40;
  localparam int  MAX_REQ_CYCLES = 400;
  localparam time TIMEOUT        = (NUM_REQ * MAX_REQ_CYCLES + 100) * CLK_PERIOD;

  logic clk = 1'b0;
  logic rstn;
  mcu_req_t req_i;
  logic st_vld_i, ld_vld_i;
  logic vlane_store_dvalid_i, ctrl_wdone_i, wr_tready_i;
  buf_stat_t sbuff_stat_i, ldbuff_stat_i;
  logic rd_tvalid_i, rd_tlast_i, vlane_load_rdy_i;
  logic st_rdy_o, store_cfg_update_o, vlane_store_rdy_o;
  logic store_baseaddr_set_o, store_baseaddr_update_o, ctrl_wstart_o, wr_tvalid_o;
  logic [ADDR_W-1:0] store_baseaddr_o;
  buf_ctrl_t sbuff_ctrl_o, ldbuff_ctrl_o;
  logic ld_rdy_o, ld_buffered_o, load_cfg_update_o, load_baseaddr_set_o;
  logic ctrl_rstart_o, rd_tready_o, vlane_load_dvalid_o, vlane_load_last_o;
  logic [VL_W-1:0] cfg_vl_o;
  vec_cfg_t st_cfg_o, ld_cfg_o;

  integer seed = 12889;
  int checks = 0;
  int errors = 0;
  // Buffer fill and drain counters and burst lengths
  int s_wcnt = 0, s_rcnt = 0, s_len = 1;
  int l_wcnt = 0, l_rcnt = 0, l_len = 1;
  // Pulse counts of the running request
  int n_wstart, n_wdone, n_bupd, n_rstart, n_last;
  // AXI responder state
  logic wd_arm = 1'b0, rd_arm = 1'b0, draining = 1'b0;
  int wd_wait = 0, drain_cnt = 0, rd_left = 0, rd_gap = 0;
  logic strided_st = 1'b0, unit_st = 1'b0;
  logic prev_tvalid = 1'b0, prev_tready = 1'b0, prev_last = 1'b0, prev_buf = 1'b0;

  m_cu_top DUT (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  // Reserved LMUL or an out-of-range signed log2 sum gives 0
  function automatic logic [2:0] expected_emul(input logic [2:0] dw, input logic [2:0] lmul,
                                               input logic [2:0] sew);
    int lmul_log2;
    int emul_log2;
    lmul_log2 = lmul[2] ? int'(lmul) - 8 : int'(lmul);
    emul_log2 = lmul_log2 + int'(dw) - int'(sew);
    if (lmul == 3'd4 || emul_log2 > 3 || emul_log2 < -3)
      return 3'd0;
    return emul_log2[2:0];
  endfunction

  ////////////////////////////////////////////////////////////
  // Buffer and AXI responders driven on the rising edge
  ////////////////////////////////////////////////////////////
  always @(posedge clk) begin : drive_responders
    int r;
    r = $random(seed);
    vlane_store_dvalid_i <= (r[1:0] != 2'b00);
    wr_tready_i          <= r[2];
    vlane_load_rdy_i     <= (r[4:3] != 2'b00);
    sbuff_stat_i  <= {s_wcnt > s_rcnt, s_wcnt >= s_len, s_rcnt >= s_len};
    ldbuff_stat_i <= {l_wcnt > l_rcnt, l_wcnt >= l_len, l_rcnt >= l_len};
    if (wd_arm) begin
      wd_wait = 1 + r[6:5];
      wd_arm  = 1'b0;
    end
    ctrl_wdone_i <= (wd_wait == 1);
    if (wd_wait > 0)
      wd_wait--;
    if (rd_arm) begin
      rd_left = l_len;
      rd_gap  = r[8:7];
      rd_arm  = 1'b0;
    end
    rd_tvalid_i <= 1'b0;
    rd_tlast_i  <= 1'b0;
    if (rd_gap > 0)
      rd_gap--;
    else if (rd_left > 0 && r[9]) begin
      rd_tvalid_i <= 1'b1;
      rd_tlast_i  <= (rd_left == 1);
      rd_left--;
    end
  end

  ////////////////////////////////////////////////////////////
  // Mid-cycle sampling of counters and per-cycle checks
  ////////////////////////////////////////////////////////////
  always @(negedge clk) begin : monitor
    if (rstn) begin
      if (sbuff_ctrl_o.cntr_rst) begin
        s_wcnt = 0;
        s_rcnt = 0;
      end else begin
        s_wcnt += sbuff_ctrl_o.wen;
        s_rcnt += sbuff_ctrl_o.ren;
      end
      if (ldbuff_ctrl_o.cntr_rst) begin
        l_wcnt = 0;
        l_rcnt = 0;
      end else begin
        l_wcnt += ldbuff_ctrl_o.wen;
        l_rcnt += ldbuff_ctrl_o.ren;
      end
      n_wstart += ctrl_wstart_o;
      n_wdone  += ctrl_wdone_i;
      n_bupd   += store_baseaddr_update_o;
      n_rstart += ctrl_rstart_o;
      n_last   += vlane_load_last_o;
      if (ctrl_wstart_o && strided_st)
        wd_arm = 1'b1;
      if (ctrl_wstart_o && unit_st)
        draining = 1'b1;
      // Unit store completes once the valid line has shifted out
      if (draining && sbuff_stat_i.read_done && wr_tready_i)
        drain_cnt++;
      if (drain_cnt == 3) begin
        wd_arm    = 1'b1;
        draining  = 1'b0;
        drain_cnt = 0;
      end
      if (ctrl_rstart_o)
        rd_arm = 1'b1;
      if (unit_st && wr_tvalid_o && !prev_tvalid)
        check_val("wr_tready_i before wr_tvalid_o rise", prev_tready, 1);
      if (prev_last)
        check_val("ld_rdy_o after last", ld_rdy_o, 1);
      if (prev_buf && !prev_last)
        check_val("ld_buffered_o", ld_buffered_o, 1);
      prev_tvalid = wr_tvalid_o;
      prev_tready = wr_tready_i;
      prev_last   = vlane_load_last_o;
      prev_buf    = ld_buffered_o;
    end
  end

  task automatic run_request(input logic is_load);
    mcu_req_t r;
    int       pick;
    int       len;
    r.sew        = $random(seed);
    r.lmul       = $random(seed);
    r.data_width = $random(seed);
    r.base_addr  = $random(seed);
    r.stride     = $random(seed);
    r.vl         = $random(seed);
    pick         = $unsigned($random(seed)) % 3;
    r.kind       = mem_kind_e'(3'b001 << pick);
    len          = 1 + $unsigned($random(seed)) % 8;
    if (is_load)
      l_len = len;
    else
      s_len = len;
    @(posedge clk);
    n_wstart   = 0;
    n_wdone    = 0;
    n_bupd     = 0;
    n_rstart   = 0;
    n_last     = 0;
    strided_st = !is_load && (r.kind == STRIDED);
    unit_st    = !is_load && (r.kind != STRIDED);
    req_i    <= r;
    st_vld_i <= !is_load;
    ld_vld_i <= is_load;
    // Base address strobe in the same cycle as the request
    @(negedge clk);
    check_val("store_baseaddr_set_o", store_baseaddr_set_o, !is_load);
    check_val("load_baseaddr_set_o", load_baseaddr_set_o, is_load);
    check_val("store_baseaddr_o", store_baseaddr_o, r.base_addr);
    @(posedge clk);
    st_vld_i <= 1'b0;
    ld_vld_i <= 1'b0;
    // Configuration and update pulse one cycle after the strobe
    @(negedge clk);
    check_val("cfg_vl_o", cfg_vl_o, r.vl);
    if (is_load) begin
      check_val("load_cfg_update_o", load_cfg_update_o, 1);
      check_val("ld_cfg_o", ld_cfg_o, {r.data_width, expected_emul(r.data_width, r.lmul, r.sew)});
    end else begin
      check_val("store_cfg_update_o", store_cfg_update_o, 1);
      check_val("st_cfg_o", st_cfg_o, {r.data_width, expected_emul(r.data_width, r.lmul, r.sew)});
    end
    @(negedge clk);
    check_val("cfg_update_o width", is_load ? load_cfg_update_o : store_cfg_update_o, 0);
    while (!(is_load ? ld_rdy_o : st_rdy_o))
      @(negedge clk);
    if (is_load) begin
      check_val("ctrl_rstart_o pulses", n_rstart, 1);
      check_val("vlane_load_last_o pulses", n_last, 1);
    end else if (strided_st) begin
      check_val("store_baseaddr_update_o pulses", n_bupd, n_wdone);
      check_val("sbuff_stat_i.read_done at st_rdy_o", sbuff_stat_i.read_done, 1);
    end else begin
      check_val("ctrl_wstart_o pulses", n_wstart, 1);
      check_val("ctrl_wdone_i pulses", n_wdone, 1);
    end
  endtask

  initial begin : main
    int coin;
    rstn = 1'b0;
    req_i = '0;
    st_vld_i = 1'b0;
    ld_vld_i = 1'b0;
    vlane_store_dvalid_i = 1'b0;
    sbuff_stat_i = '0;
    ctrl_wdone_i = 1'b0;
    wr_tready_i = 1'b0;
    ldbuff_stat_i = '0;
    rd_tvalid_i = 1'b0;
    rd_tlast_i = 1'b0;
    vlane_load_rdy_i = 1'b0;
    repeat (8) @(posedge clk);
    rstn <= 1'b1;
    @(negedge clk);
    // Idle values after reset
    check_val("st_rdy_o", st_rdy_o, 1);
    check_val("ld_rdy_o", ld_rdy_o, 1);
    check_val("store_cfg_update_o", store_cfg_update_o, 0);
    check_val("load_cfg_update_o", load_cfg_update_o, 0);
    check_val("sbuff_ctrl_o", sbuff_ctrl_o, 0);
    check_val("ldbuff_ctrl_o", ldbuff_ctrl_o, 0);
    check_val("ctrl_wstart_o", ctrl_wstart_o, 0);
    check_val("ctrl_rstart_o", ctrl_rstart_o, 0);
    check_val("wr_tvalid_o", wr_tvalid_o, 0);
    check_val("store_baseaddr_update_o", store_baseaddr_update_o, 0);
    check_val("store_baseaddr_set_o", store_baseaddr_set_o, 0);
    check_val("load_baseaddr_set_o", load_baseaddr_set_o, 0);
    check_val("vlane_store_rdy_o", vlane_store_rdy_o, 0);
    check_val("vlane_load_dvalid_o", vlane_load_dvalid_o, 0);
    check_val("vlane_load_last_o", vlane_load_last_o, 0);
    check_val("ld_buffered_o", ld_buffered_o, 0);
    check_val("rd_tready_o", rd_tready_o, 0);
    for (int i = 0; i < NUM_REQ; i++) begin
      coin = $random(seed);
      run_request(coin[0]);
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

  initial begin : watchdog
    #(TIMEOUT);
    $display("Timeout: a request did not complete in the expected time");
    $display("Checks: %0d, errors: %0d", checks, errors + 1);
    $display("Errors found");
    $finish;
  end

endmodule : m_cu_tb

`default_nettype wire

/* design/emul_lookup.sv */
/*
  Purely combinational. Codes are signed log2 values, LMUL code 4 is reserved.
  Any result outside 1/8..8 gives code 0.
*/
`timescale 1ns/1ps
`default_nettype none

module emul_lookup (
  input  mcu_pkg::vtype_t data_width_i,
  input  mcu_pkg::vtype_t lmul_i,
  input  mcu_pkg::vtype_t sew_i,
  output mcu_pkg::vtype_t emul_o
);

  import mcu_pkg::*;

  // Two guard bits cover the full -11..10 range of the sum
  logic signed [VTYPE_W+1:0] lmul_s;
  logic signed [VTYPE_W+1:0] sum_s;
  logic                      lmul_rsvd;
  logic                      out_of_range;

  assign lmul_s = signed'({{2{lmul_i[VTYPE_W-1]}}, lmul_i});

  // EMUL = LMUL * EEW / SEW, as a sum of log2 values
  assign sum_s = lmul_s + signed'({2'b00, data_width_i}) - signed'({2'b00, sew_i});

  assign lmul_rsvd    = (lmul_i == LMUL_RSVD);
  assign out_of_range = (sum_s > EMUL_MAX) || (sum_s < EMUL_MIN);

  assign emul_o = (lmul_rsvd || out_of_range) ? '0 : sum_s[VTYPE_W-1:0];

endmodule : emul_lookup

`default_nettype wire

/* design/load_ctrl.sv */
/*
  Unit-stride loads only. The buffer fills from the AXI read stream, then
  drains to the lanes through a 3-stage valid line. Last marks the final handshake.
*/
`timescale 1ns/1ps
`default_nettype none

module load_ctrl (
  input  logic               clk,
  input  logic               rstn,
  input  logic               ld_vld_i,
  input  mcu_pkg::buf_stat_t ldbuff_stat_i,
  input  logic               rd_tvalid_i,
  input  logic               rd_tlast_i,
  input  logic               vlane_load_rdy_i,
  output logic               ld_rdy_o,
  output logic               ld_save_o,
  output logic               ld_buffered_o,
  output logic               cfg_update_o,
  output mcu_pkg::buf_ctrl_t ldbuff_ctrl_o,
  output logic               baseaddr_set_o,
  output logic               ctrl_rstart_o,
  output logic               rd_tready_o,
  output logic               vlane_load_dvalid_o,
  output logic               vlane_load_last_o
);

  import mcu_pkg::*;

  load_state_e             state_q, state_d;
  logic                    vld_q;
  logic                    start, start_q;
  logic                    rv_in;
  logic [WVALID_DEPTH-1:0] rv_q;
  logic                    only_last;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state_q <= LD_IDLE;
      vld_q   <= 1'b0;
      start_q <= 1'b0;
      rv_q    <= '0;
    end else begin
      state_q <= state_d;
      vld_q   <= ld_vld_i;
      start_q <= start;
      if (!ldbuff_ctrl_o.read_stall)
        rv_q <= {rv_q[WVALID_DEPTH-2:0], rv_in};
    end
  end

  // Only the final stage full
  assign only_last = rv_q[WVALID_DEPTH-1] && (rv_q[WVALID_DEPTH-2:0] == '0);

  assign vlane_load_dvalid_o = ldbuff_stat_i.read_done ? rv_q[WVALID_DEPTH-1]
                                                       : rv_q[WVALID_DEPTH-2];
  assign vlane_load_last_o   = (state_q == LD_UNIT_TX) && only_last && vlane_load_rdy_i;
  assign ctrl_rstart_o       = start & ~start_q;

  always_comb begin
    state_d        = state_q;
    ld_rdy_o       = 1'b0;
    ld_save_o      = 1'b0;
    ld_buffered_o  = 1'b0;
    cfg_update_o   = 1'b0;
    ldbuff_ctrl_o  = '0;
    baseaddr_set_o = 1'b0;
    start          = 1'b0;
    rd_tready_o    = 1'b0;
    rv_in          = 1'b0;

    case (state_q)
      LD_IDLE: begin
        ld_rdy_o = 1'b1;
        if (vld_q) begin
          ld_rdy_o               = 1'b0;
          cfg_update_o           = 1'b1;
          ldbuff_ctrl_o.cntr_rst = 1'b1;
          state_d                = LD_UNIT_PREP;
        end else if (ld_vld_i) begin
          ld_save_o      = 1'b1;
          baseaddr_set_o = 1'b1;
        end
      end
      LD_UNIT_PREP: begin
        start             = 1'b1;
        rd_tready_o       = 1'b1;
        ldbuff_ctrl_o.wen = rd_tvalid_i;
        if (rd_tlast_i && rd_tvalid_i) begin
          rv_in             = 1'b1;
          ldbuff_ctrl_o.ren = 1'b1;
          state_d           = LD_UNIT_TX;
        end
      end
      LD_UNIT_TX: begin
        ld_buffered_o = 1'b1;
        rv_in         = ~(ldbuff_stat_i.read_done && vlane_load_rdy_i);
        ldbuff_ctrl_o.ren        = rv_in && vlane_load_rdy_i;
        ldbuff_ctrl_o.read_stall = ~vlane_load_rdy_i;
        if (vlane_load_last_o)
          state_d = LD_IDLE;
      end
      default: state_d = LD_IDLE;
    endcase
  end

endmodule : load_ctrl

`default_nettype wire

/* design/m_cu_top.sv */
/*
  Memory control unit between scheduler, vector buffers, lanes and AXI master.
  Indexed and strided loads are not supported.
*/
`timescale 1ns/1ps
`default_nettype none

module m_cu_top (
  input  logic                       clk,
  input  logic                       rstn,
  input  mcu_pkg::mcu_req_t          req_i,
  input  logic                       st_vld_i,
  input  logic                       ld_vld_i,
  // Store side
  input  logic                       vlane_store_dvalid_i,
  input  mcu_pkg::buf_stat_t         sbuff_stat_i,
  input  logic                       ctrl_wdone_i,
  input  logic                       wr_tready_i,
  output logic                       st_rdy_o,
  output logic                       store_cfg_update_o,
  output mcu_pkg::buf_ctrl_t         sbuff_ctrl_o,
  output logic                       vlane_store_rdy_o,
  output logic                       store_baseaddr_set_o,
  output logic                       store_baseaddr_update_o,
  output logic [mcu_pkg::ADDR_W-1:0] store_baseaddr_o,
  output logic                       ctrl_wstart_o,
  output logic                       wr_tvalid_o,
  // Load side
  input  mcu_pkg::buf_stat_t         ldbuff_stat_i,
  input  logic                       rd_tvalid_i,
  input  logic                       rd_tlast_i,
  input  logic                       vlane_load_rdy_i,
  output logic                       ld_rdy_o,
  output logic                       ld_buffered_o,
  output logic                       load_cfg_update_o,
  output mcu_pkg::buf_ctrl_t         ldbuff_ctrl_o,
  output logic                       load_baseaddr_set_o,
  output logic                       ctrl_rstart_o,
  output logic                       rd_tready_o,
  output logic                       vlane_load_dvalid_o,
  output logic                       vlane_load_last_o,
  // Buffer array configuration
  output logic [mcu_pkg::VL_W-1:0]   cfg_vl_o,
  output mcu_pkg::vec_cfg_t          st_cfg_o,
  output mcu_pkg::vec_cfg_t          ld_cfg_o
);

  import mcu_pkg::*;

  vtype_t    emul;
  logic      st_save;
  logic      ld_save;
  mem_kind_e st_kind;

  assign cfg_vl_o = req_i.vl;

  emul_lookup u_emul (
    .data_width_i (req_i.data_width),
    .lmul_i       (req_i.lmul),
    .sew_i        (req_i.sew),
    .emul_o       (emul)
  );

  // Load kind is not needed while only unit loads exist
  mcu_cfg_regs u_cfg (
    .clk       (clk),
    .rstn      (rstn),
    .req_i     (req_i),
    .emul_i    (emul),
    .st_save_i (st_save),
    .ld_save_i (ld_save),
    .st_kind_o (st_kind),
    .ld_kind_o (),
    .st_cfg_o  (st_cfg_o),
    .ld_cfg_o  (ld_cfg_o)
  );

  store_ctrl u_store (
    .clk                  (clk),
    .rstn                 (rstn),
    .st_vld_i             (st_vld_i),
    .kind_i               (st_kind),
    .base_addr_i          (req_i.base_addr),
    .vlane_store_dvalid_i (vlane_store_dvalid_i),
    .sbuff_stat_i         (sbuff_stat_i),
    .ctrl_wdone_i         (ctrl_wdone_i),
    .wr_tready_i          (wr_tready_i),
    .st_rdy_o             (st_rdy_o),
    .st_save_o            (st_save),
    .cfg_update_o         (store_cfg_update_o),
    .sbuff_ctrl_o         (sbuff_ctrl_o),
    .vlane_store_rdy_o    (vlane_store_rdy_o),
    .baseaddr_set_o       (store_baseaddr_set_o),
    .baseaddr_update_o    (store_baseaddr_update_o),
    .baseaddr_o           (store_baseaddr_o),
    .ctrl_wstart_o        (ctrl_wstart_o),
    .wr_tvalid_o          (wr_tvalid_o)
  );

  load_ctrl u_load (
    .clk                 (clk),
    .rstn                (rstn),
    .ld_vld_i            (ld_vld_i),
    .ldbuff_stat_i       (ldbuff_stat_i),
    .rd_tvalid_i         (rd_tvalid_i),
    .rd_tlast_i          (rd_tlast_i),
    .vlane_load_rdy_i    (vlane_load_rdy_i),
    .ld_rdy_o            (ld_rdy_o),
    .ld_save_o           (ld_save),
    .ld_buffered_o       (ld_buffered_o),
    .cfg_update_o        (load_cfg_update_o),
    .ldbuff_ctrl_o       (ldbuff_ctrl_o),
    .baseaddr_set_o      (load_baseaddr_set_o),
    .ctrl_rstart_o       (ctrl_rstart_o),
    .rd_tready_o         (rd_tready_o),
    .vlane_load_dvalid_o (vlane_load_dvalid_o),
    .vlane_load_last_o   (vlane_load_last_o)
  );

endmodule : m_cu_top

`default_nettype wire

/* design/mcu_cfg_regs.sv */
/*
  One configuration set per direction, loaded on its save strobe.
  Outputs change one cycle after the strobe and hold until the next one.
*/
`timescale 1ns/1ps
`default_nettype none

module mcu_cfg_regs (
  input  logic                clk,
  input  logic                rstn,
  input  mcu_pkg::mcu_req_t   req_i,
  input  mcu_pkg::vtype_t     emul_i,
  input  logic                st_save_i,
  input  logic                ld_save_i,
  output mcu_pkg::mem_kind_e  st_kind_o,
  output mcu_pkg::mem_kind_e  ld_kind_o,
  output mcu_pkg::vec_cfg_t   st_cfg_o,
  output mcu_pkg::vec_cfg_t   ld_cfg_o
);

  import mcu_pkg::*;

  // Index 0 is the store side, index 1 the load side
  logic      save[2];
  mem_kind_e kind_q[2];
  vec_cfg_t  cfg_q[2];

  assign save[0] = st_save_i;
  assign save[1] = ld_save_i;

  for (genvar d = 0; d < 2; d++) begin : g_dir
    always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
        kind_q[d] <= UNIT;
        cfg_q[d]  <= '0;
      end else if (save[d]) begin
        kind_q[d]          <= req_i.kind;
        cfg_q[d].data_sew  <= req_i.data_width;
        cfg_q[d].data_lmul <= emul_i;
      end
    end
  end

  assign st_kind_o = kind_q[0];
  assign ld_kind_o = kind_q[1];
  assign st_cfg_o  = cfg_q[0];
  assign ld_cfg_o  = cfg_q[1];

endmodule : mcu_cfg_regs

`default_nettype wire

/* design/mcu_pkg.sv */
/*
  Shared widths, encodings and port structs of the memory control unit.
  Indexed requests are accepted but run as unit-stride.
*/
`default_nettype none

package mcu_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////
  localparam int VLEN         = 8192;
  localparam int VL_W         = $clog2(VLEN);
  localparam int ADDR_W       = 32;
  localparam int VTYPE_W      = 3;
  localparam int WVALID_DEPTH = 3;

  // EMUL range as signed log2 and the reserved LMUL code
  localparam int                 EMUL_MAX  = 3;
  localparam int                 EMUL_MIN  = -3;
  localparam logic [VTYPE_W-1:0] LMUL_RSVD = 3'b100;

  ////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////
  typedef logic [VTYPE_W-1:0] vtype_t;

  // One-hot request kind, same bit order as the scheduler fields
  typedef enum logic [2:0] {
    INDEXED = 3'b001,
    STRIDED = 3'b010,
    UNIT    = 3'b100
  } mem_kind_e;

  typedef struct packed {
    vtype_t            sew;
    vtype_t            lmul;
    vtype_t            data_width;
    logic [ADDR_W-1:0] base_addr;
    logic [ADDR_W-1:0] stride;
    mem_kind_e         kind;
    logic [VL_W-1:0]   vl;
  } mcu_req_t;

  typedef struct packed {
    vtype_t data_sew;
    vtype_t data_lmul;
  } vec_cfg_t;

  typedef struct packed {
    logic wen;
    logic ren;
    logic read_stall;
    logic cntr_rst;
  } buf_ctrl_t;

  typedef struct packed {
    logic not_empty;
    logic write_done;
    logic read_done;
  } buf_stat_t;

  typedef enum logic [2:0] {
    ST_IDLE, ST_UNIT_PREP, ST_UNIT_TX, ST_STRIDED_PREP, ST_STRIDED_TX_PREP, ST_STRIDED_TX
  } store_state_e;

  typedef enum logic [1:0] {
    LD_IDLE, LD_UNIT_PREP, LD_UNIT_TX
  } load_state_e;

endpackage : mcu_pkg

`default_nettype wire

/* design/store_ctrl.sv */
/*
  Unit and strided stores. Indexed kind runs as unit-stride.
  Write data is taken from the store buffer through a 3-stage valid line.
*/
`timescale 1ns/1ps
`default_nettype none

module store_ctrl (
  input  logic                      clk,
  input  logic                      rstn,
  input  logic                      st_vld_i,
  input  mcu_pkg::mem_kind_e        kind_i,
  input  logic [mcu_pkg::ADDR_W-1:0] base_addr_i,
  input  logic                      vlane_store_dvalid_i,
  input  mcu_pkg::buf_stat_t        sbuff_stat_i,
  input  logic                      ctrl_wdone_i,
  input  logic                      wr_tready_i,
  output logic                      st_rdy_o,
  output logic                      st_save_o,
  output logic                      cfg_update_o,
  output mcu_pkg::buf_ctrl_t        sbuff_ctrl_o,
  output logic                      vlane_store_rdy_o,
  output logic                      baseaddr_set_o,
  output logic                      baseaddr_update_o,
  output logic [mcu_pkg::ADDR_W-1:0] baseaddr_o,
  output logic                      ctrl_wstart_o,
  output logic                      wr_tvalid_o
);

  import mcu_pkg::*;

  store_state_e            state_q, state_d;
  logic                    vld_q;
  logic                    start, start_q;
  logic                    wv_in;
  logic [WVALID_DEPTH-1:0] wv_q;
  logic                    invalidate;
  logic                    wv_out;

  ////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state_q <= ST_IDLE;
      vld_q   <= 1'b0;
      start_q <= 1'b0;
      wv_q    <= '0;
    end else begin
      state_q <= state_d;
      vld_q   <= st_vld_i;
      start_q <= start;
      // Line holds while the AXI side back-pressures
      if (!sbuff_ctrl_o.read_stall)
        wv_q <= {wv_q[WVALID_DEPTH-2:0], wv_in};
    end
  end

  // Buffer output register adds a stage once reading is done
  assign wv_out        = sbuff_stat_i.read_done ? wv_q[WVALID_DEPTH-1] : wv_q[WVALID_DEPTH-2];
  assign wr_tvalid_o   = invalidate ? 1'b0 : wv_out;
  assign ctrl_wstart_o = start & ~start_q;
  assign baseaddr_o    = base_addr_i;

  ////////////////////////////////////////////////////////////
  // Next state and control
  ////////////////////////////////////////////////////////////
  always_comb begin
    state_d           = state_q;
    st_rdy_o          = 1'b0;
    st_save_o         = 1'b0;
    cfg_update_o      = 1'b0;
    sbuff_ctrl_o      = '0;
    vlane_store_rdy_o = 1'b0;
    baseaddr_set_o    = 1'b0;
    baseaddr_update_o = 1'b0;
    start             = 1'b0;
    wv_in             = 1'b0;
    invalidate        = 1'b0;

    case (state_q)
      ST_IDLE: begin
        st_rdy_o = 1'b1;
        if (vld_q) begin
          st_rdy_o              = 1'b0;
          cfg_update_o          = 1'b1;
          sbuff_ctrl_o.cntr_rst = 1'b1;
          state_d = (kind_i == STRIDED) ? ST_STRIDED_PREP : ST_UNIT_PREP;
        end else if (st_vld_i) begin
          st_save_o      = 1'b1;
          baseaddr_set_o = 1'b1;
        end
      end
      ST_UNIT_PREP: begin
        vlane_store_rdy_o = 1'b1;
        sbuff_ctrl_o.wen  = vlane_store_dvalid_i;
        if (sbuff_stat_i.write_done && vlane_store_dvalid_i) begin
          // Pre-read the first word
          start            = 1'b1;
          wv_in            = 1'b1;
          sbuff_ctrl_o.ren = 1'b1;
          state_d          = ST_UNIT_TX;
        end
      end
      ST_UNIT_TX: begin
        wv_in            = ~(sbuff_stat_i.read_done && wr_tready_i);
        sbuff_ctrl_o.ren = wv_in && wr_tready_i;
        sbuff_ctrl_o.read_stall = ~wr_tready_i;
        if (ctrl_wdone_i)
          state_d = ST_IDLE;
      end
      ST_STRIDED_PREP: begin
        vlane_store_rdy_o = 1'b1;
        sbuff_ctrl_o.wen  = vlane_store_dvalid_i && !sbuff_stat_i.write_done;
        if (sbuff_stat_i.write_done) begin
          baseaddr_set_o   = 1'b1;
          sbuff_ctrl_o.ren = 1'b1;
          wv_in            = 1'b1;
          state_d          = ST_STRIDED_TX_PREP;
        end
      end
      // One element per burst, the output is hidden while re-arming
      ST_STRIDED_TX_PREP: begin
        sbuff_ctrl_o.ren = ~sbuff_stat_i.read_done;
        wv_in            = ~sbuff_stat_i.read_done;
        start            = 1'b1;
        invalidate       = 1'b1;
        state_d          = ST_STRIDED_TX;
      end
      ST_STRIDED_TX: begin
        sbuff_ctrl_o.read_stall = 1'b1;
        invalidate              = ~wr_tready_i;
        if (ctrl_wdone_i) begin
          baseaddr_update_o = 1'b1;
          if (sbuff_stat_i.read_done && (wv_q[1:0] == '0))
            state_d = ST_IDLE;
          else
            state_d = ST_STRIDED_TX_PREP;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

endmodule : store_ctrl

`default_nettype wire

/* verilog.f */
design/mcu_pkg.sv
design/emul_lookup.sv
design/mcu_cfg_regs.sv
design/store_ctrl.sv
design/load_ctrl.sv
design/m_cu_top.sv
bench/m_cu_tb.sv
